/* ex_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage shared types
// instruction codes, datapath words, register numbers
// and the divider step count
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package ex_pkg;

    // operand / result word
    typedef logic [31:0] word_t;
    // HI in the upper word, LO in the lower
    typedef logic [63:0] dword_t;
    // zero means no writeback
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] imm_t;

    // internal instruction codes from the decoder
    typedef enum logic [7:0] {
        INST_NOP   = 8'h00,
        INST_ADD   = 8'h01,
        INST_ADDU  = 8'h02,
        INST_SUB   = 8'h03,
        INST_SUBU  = 8'h04,
        INST_ADDI  = 8'h05,
        INST_ADDIU = 8'h06,
        INST_SLT   = 8'h07,
        INST_SLTU  = 8'h08,
        INST_SLTI  = 8'h09,
        INST_SLTIU = 8'h0a,
        INST_AND   = 8'h10,
        INST_ANDI  = 8'h11,
        INST_OR    = 8'h12,
        INST_ORI   = 8'h13,
        INST_XOR   = 8'h14,
        INST_XORI  = 8'h15,
        INST_NOR   = 8'h16,
        INST_LUI   = 8'h17,
        INST_SLL   = 8'h20,
        INST_SLLV  = 8'h21,
        INST_SRL   = 8'h22,
        INST_SRLV  = 8'h23,
        INST_SRA   = 8'h24,
        INST_SRAV  = 8'h25,
        INST_CLZ   = 8'h28,
        INST_CLO   = 8'h29,
        INST_MOVZ  = 8'h30,
        INST_MOVN  = 8'h31,
        INST_MUL   = 8'h38,
        INST_MULT  = 8'h39,
        INST_MULTU = 8'h3a,
        INST_DIV   = 8'h3b,
        INST_DIVU  = 8'h3c,
        INST_MFHI  = 8'h40,
        INST_MFLO  = 8'h41,
        INST_MTHI  = 8'h42,
        INST_MTLO  = 8'h43
    } inst_t;

    // sequential divider states
    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_RUN  = 2'd1,
        DIV_DONE = 2'd2
    } div_state_t;

    // one quotient bit per cycle
    localparam int unsigned DIV_STEPS = 32;

endpackage

`default_nettype wire

/* ex_bitops.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shift and bit count unit
// barrel shifts plus leading zero / one counting
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ex_bitops (
    input  wire ex_pkg::inst_t  inst_i,
    input  wire ex_pkg::word_t  rs_val_i,
    input  wire ex_pkg::word_t  rt_val_i,
    input  wire ex_pkg::shamt_t shamt_i,
    output ex_pkg::word_t       bit_val_o
);

    ex_pkg::shamt_t sh_amt;
    ex_pkg::word_t  scan;
    logic [5:0]     lead_cnt;

    // variable forms take the amount from rs
    assign sh_amt = ((inst_i == ex_pkg::INST_SLLV) || (inst_i == ex_pkg::INST_SRLV) ||
                     (inst_i == ex_pkg::INST_SRAV)) ? rs_val_i[4:0] : shamt_i;

    // CLO is CLZ of the inverted word
    assign scan = (inst_i == ex_pkg::INST_CLO) ? ~rs_val_i : rs_val_i;

    // highest set bit wins, 32 when none
    always_comb
    begin
        lead_cnt = 6'd32;
        for (int i = 0; i < 32; i++)
        begin
            if (scan[i])
                lead_cnt = 6'(31 - i);
        end
    end

    always_comb
    begin
        case (inst_i)
            ex_pkg::INST_SLL, ex_pkg::INST_SLLV:
                bit_val_o = rt_val_i << sh_amt;
            ex_pkg::INST_SRL, ex_pkg::INST_SRLV:
                bit_val_o = rt_val_i >> sh_amt;
            ex_pkg::INST_SRA, ex_pkg::INST_SRAV:
                bit_val_o = ex_pkg::word_t'($signed(rt_val_i) >>> sh_amt);
            ex_pkg::INST_CLZ, ex_pkg::INST_CLO:
                bit_val_o = {26'h0, lead_cnt};
            default:
                bit_val_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* ex_alu.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute ALU
// add/sub, compare and logic ops, writeback select,
// overflow and destination choice, MTHI/MTLO requests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
    input  wire ex_pkg::inst_t     inst_i,
    input  wire ex_pkg::reg_addr_t reg_t_i,
    input  wire ex_pkg::reg_addr_t reg_d_i,
    input  wire ex_pkg::word_t     rs_val_i,
    input  wire ex_pkg::word_t     rt_val_i,
    input  wire ex_pkg::word_t     mul_val_i,
    input  wire ex_pkg::word_t     bit_val_i,
    input  wire ex_pkg::imm_t      imm_i,
    input  wire ex_pkg::dword_t    hilo_i,
    output ex_pkg::word_t          val_o,
    output ex_pkg::reg_addr_t      wb_addr_o,
    output logic                   overflow_o,
    output logic                   move_hi_en_o,
    output logic                   move_lo_en_o,
    output ex_pkg::word_t          move_val_o
);

    ex_pkg::word_t     sext_imm;
    ex_pkg::word_t     zext_imm;
    ex_pkg::word_t     op_b;
    ex_pkg::word_t     add_b;
    ex_pkg::word_t     sum;
    ex_pkg::word_t     res_val;
    ex_pkg::reg_addr_t dest;
    logic              is_sub;
    logic              is_imm;
    logic              is_trap;
    logic              add_ovf;
    logic              lt_s;
    logic              lt_u;

    assign sext_imm = {{16{imm_i[15]}}, imm_i};
    assign zext_imm = {16'h0, imm_i};

    assign is_sub = (inst_i == ex_pkg::INST_SUB) || (inst_i == ex_pkg::INST_SUBU);
    assign is_imm = (inst_i == ex_pkg::INST_ADDI) || (inst_i == ex_pkg::INST_ADDIU) ||
                    (inst_i == ex_pkg::INST_SLTI) || (inst_i == ex_pkg::INST_SLTIU);
    assign is_trap = (inst_i == ex_pkg::INST_ADD) || (inst_i == ex_pkg::INST_SUB) ||
                     (inst_i == ex_pkg::INST_ADDI);

    // subtract as rs + ~b + 1
    assign op_b  = is_imm ? sext_imm : rt_val_i;
    assign add_b = is_sub ? ~op_b : op_b;
    assign sum   = rs_val_i + add_b + ex_pkg::word_t'(is_sub);

    // same-sign inputs, different-sign result
    assign add_ovf = (rs_val_i[31] == add_b[31]) && (sum[31] != rs_val_i[31]);

    assign lt_s = $signed(rs_val_i) < $signed(op_b);
    assign lt_u = rs_val_i < op_b;

    always_comb
    begin
        res_val = '0;
        dest    = '0;
        case (inst_i)
            ex_pkg::INST_ADD, ex_pkg::INST_ADDU,
            ex_pkg::INST_SUB, ex_pkg::INST_SUBU:
            begin
                res_val = sum;
                dest    = reg_d_i;
            end
            ex_pkg::INST_ADDI, ex_pkg::INST_ADDIU:
            begin
                res_val = sum;
                dest    = reg_t_i;
            end
            ex_pkg::INST_SLT:   begin res_val = {31'h0, lt_s}; dest = reg_d_i; end
            ex_pkg::INST_SLTU:  begin res_val = {31'h0, lt_u}; dest = reg_d_i; end
            ex_pkg::INST_SLTI:  begin res_val = {31'h0, lt_s}; dest = reg_t_i; end
            ex_pkg::INST_SLTIU: begin res_val = {31'h0, lt_u}; dest = reg_t_i; end
            ex_pkg::INST_AND:   begin res_val = rs_val_i & rt_val_i; dest = reg_d_i; end
            ex_pkg::INST_ANDI:  begin res_val = rs_val_i & zext_imm; dest = reg_t_i; end
            ex_pkg::INST_OR:    begin res_val = rs_val_i | rt_val_i; dest = reg_d_i; end
            ex_pkg::INST_ORI:   begin res_val = rs_val_i | zext_imm; dest = reg_t_i; end
            ex_pkg::INST_XOR:   begin res_val = rs_val_i ^ rt_val_i; dest = reg_d_i; end
            ex_pkg::INST_XORI:  begin res_val = rs_val_i ^ zext_imm; dest = reg_t_i; end
            ex_pkg::INST_NOR:   begin res_val = ~(rs_val_i | rt_val_i); dest = reg_d_i; end
            ex_pkg::INST_LUI:   begin res_val = {imm_i, 16'h0}; dest = reg_t_i; end
            // shifts and counts come from ex_bitops
            ex_pkg::INST_SLL, ex_pkg::INST_SLLV,
            ex_pkg::INST_SRL, ex_pkg::INST_SRLV,
            ex_pkg::INST_SRA, ex_pkg::INST_SRAV,
            ex_pkg::INST_CLZ, ex_pkg::INST_CLO:
            begin
                res_val = bit_val_i;
                dest    = reg_d_i;
            end
            // conditional moves drop the write when the test fails
            ex_pkg::INST_MOVZ:
            begin
                res_val = rs_val_i;
                dest    = (rt_val_i == '0) ? reg_d_i : '0;
            end
            ex_pkg::INST_MOVN:
            begin
                res_val = rs_val_i;
                dest    = (rt_val_i != '0) ? reg_d_i : '0;
            end
            ex_pkg::INST_MUL:  begin res_val = mul_val_i; dest = reg_d_i; end
            ex_pkg::INST_MFHI: begin res_val = hilo_i[63:32]; dest = reg_d_i; end
            ex_pkg::INST_MFLO: begin res_val = hilo_i[31:0]; dest = reg_d_i; end
            default:
            begin
                res_val = '0;
                dest    = '0;
            end
        endcase
    end

    assign overflow_o = is_trap && add_ovf;
    assign val_o      = res_val;
    // trapping overflow suppresses the register write
    assign wb_addr_o  = overflow_o ? '0 : dest;

    assign move_hi_en_o = (inst_i == ex_pkg::INST_MTHI);
    assign move_lo_en_o = (inst_i == ex_pkg::INST_MTLO);
    assign move_val_o   = rs_val_i;

endmodule

`default_nettype wire

/* ex_muldiv.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// multiply / divide unit
// single-cycle multiplier, restoring divider that
// stalls the stage one quotient bit per cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ex_muldiv (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 flush_i,
    input  wire ex_pkg::inst_t  inst_i,
    input  wire ex_pkg::word_t  rs_val_i,
    input  wire ex_pkg::word_t  rt_val_i,
    output ex_pkg::word_t       mul_val_o,
    output logic                hilo_wr_en_o,
    output ex_pkg::dword_t      hilo_wr_val_o,
    output logic                stall_o
);

    logic                signed_mul;
    logic                is_mult;
    logic                is_div;
    logic signed [32:0]  mul_a;
    logic signed [32:0]  mul_b;
    logic signed [65:0]  prod_wide;
    ex_pkg::dword_t      product;

    ex_pkg::div_state_t  state;
    logic [5:0]          step_cnt;
    logic                rs_neg;
    logic                rt_neg;
    ex_pkg::word_t       rs_mag;
    ex_pkg::word_t       rt_mag;
    ex_pkg::word_t       dsor_q;
    ex_pkg::word_t       quo_q;
    ex_pkg::word_t       rem_q;
    logic                quo_neg_q;
    logic                rem_neg_q;
    logic                div_zero_q;
    logic [32:0]         shifted;
    logic [32:0]         trial;
    ex_pkg::word_t       quo_fix;
    ex_pkg::word_t       rem_fix;

    assign is_mult = (inst_i == ex_pkg::INST_MULT) || (inst_i == ex_pkg::INST_MULTU);
    assign is_div  = (inst_i == ex_pkg::INST_DIV) || (inst_i == ex_pkg::INST_DIVU);

    // one 33x33 signed multiplier covers both signednesses
    assign signed_mul = (inst_i != ex_pkg::INST_MULTU);
    assign mul_a      = {signed_mul & rs_val_i[31], rs_val_i};
    assign mul_b      = {signed_mul & rt_val_i[31], rt_val_i};
    assign prod_wide  = mul_a * mul_b;
    assign product    = prod_wide[63:0];
    assign mul_val_o  = product[31:0];

    // divider works on magnitudes
    assign rs_neg = (inst_i == ex_pkg::INST_DIV) && rs_val_i[31];
    assign rt_neg = (inst_i == ex_pkg::INST_DIV) && rt_val_i[31];
    assign rs_mag = rs_neg ? -rs_val_i : rs_val_i;
    assign rt_mag = rt_neg ? -rt_val_i : rt_val_i;

    // bring down the next dividend bit and try the subtract
    assign shifted = {rem_q, quo_q[31]};
    assign trial   = shifted - {1'b0, dsor_q};

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state    <= ex_pkg::DIV_IDLE;
            step_cnt <= '0;
        end
        else if (flush_i)
            state <= ex_pkg::DIV_IDLE;
        else
        begin
            case (state)
                ex_pkg::DIV_IDLE:
                begin
                    if (is_div)
                    begin
                        // divide by zero skips the iterations
                        state    <= (rt_val_i == '0) ? ex_pkg::DIV_DONE : ex_pkg::DIV_RUN;
                        step_cnt <= '0;
                    end
                end
                ex_pkg::DIV_RUN:
                begin
                    step_cnt <= step_cnt + 6'd1;
                    if (step_cnt == 6'(ex_pkg::DIV_STEPS - 1))
                        state <= ex_pkg::DIV_DONE;
                end
                default:
                    state <= ex_pkg::DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == ex_pkg::DIV_IDLE && is_div)
        begin
            dsor_q     <= rt_mag;
            quo_q      <= rs_mag;
            rem_q      <= '0;
            quo_neg_q  <= rs_neg ^ rt_neg;
            rem_neg_q  <= rs_neg;
            div_zero_q <= (rt_val_i == '0);
        end
        else if (state == ex_pkg::DIV_RUN)
        begin
            // trial[32] set means the subtract borrowed
            rem_q <= trial[32] ? shifted[31:0] : trial[31:0];
            quo_q <= {quo_q[30:0], ~trial[32]};
        end
    end

    // remainder follows the dividend sign
    assign quo_fix = quo_neg_q ? -quo_q : quo_q;
    assign rem_fix = rem_neg_q ? -rem_q : rem_q;

    always_comb
    begin
        case (state)
            ex_pkg::DIV_IDLE: stall_o = is_div && !flush_i;
            ex_pkg::DIV_RUN:  stall_o = !flush_i;
            default:          stall_o = 1'b0;
        endcase
    end

    assign hilo_wr_en_o  = is_mult ||
                           (state == ex_pkg::DIV_DONE && !div_zero_q && !flush_i);
    assign hilo_wr_val_o = is_mult ? product : {rem_fix, quo_fix};

endmodule

`default_nettype wire

/* ex_hilo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HI/LO register pair
// full-pair multiply/divide write or single-half move
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ex_hilo (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 move_hi_en_i,
    input  wire                 move_lo_en_i,
    input  wire ex_pkg::word_t  move_val_i,
    input  wire                 hilo_wr_en_i,
    input  wire ex_pkg::dword_t hilo_wr_val_i,
    output ex_pkg::dword_t      hilo_o
);

    ex_pkg::dword_t hilo_q;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            hilo_q <= '0;
        // full pair from mult/div has priority
        else if (hilo_wr_en_i)
            hilo_q <= hilo_wr_val_i;
        else if (move_hi_en_i)
            hilo_q[63:32] <= move_val_i;
        else if (move_lo_en_i)
            hilo_q[31:0] <= move_val_i;
    end

    assign hilo_o = hilo_q;

endmodule

`default_nettype wire

/* ex_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MIPS32 execute stage
// ties ALU, shift/count, mul/div and HI/LO together
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    flush_i,
    input  wire ex_pkg::inst_t     inst_i,
    input  wire ex_pkg::reg_addr_t reg_s_i,
    input  wire ex_pkg::reg_addr_t reg_t_i,
    input  wire ex_pkg::reg_addr_t reg_d_i,
    input  wire ex_pkg::word_t     rs_val_i,
    input  wire ex_pkg::word_t     rt_val_i,
    input  wire ex_pkg::imm_t      imm_i,
    input  wire ex_pkg::shamt_t    shamt_i,
    output ex_pkg::word_t          val_o,
    output ex_pkg::reg_addr_t      wb_addr_o,
    output logic                   overflow_o,
    output logic                   stall_o
);

    ex_pkg::word_t  bit_val;
    ex_pkg::word_t  mul_val;
    ex_pkg::dword_t hilo;
    logic           hilo_wr_en;
    ex_pkg::dword_t hilo_wr_val;
    logic           move_hi_en;
    logic           move_lo_en;
    ex_pkg::word_t  move_val;

    ex_bitops u_bitops (
        .inst_i    (inst_i),
        .rs_val_i  (rs_val_i),
        .rt_val_i  (rt_val_i),
        .shamt_i   (shamt_i),
        .bit_val_o (bit_val)
    );

    ex_muldiv u_muldiv (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (flush_i),
        .inst_i        (inst_i),
        .rs_val_i      (rs_val_i),
        .rt_val_i      (rt_val_i),
        .mul_val_o     (mul_val),
        .hilo_wr_en_o  (hilo_wr_en),
        .hilo_wr_val_o (hilo_wr_val),
        .stall_o       (stall_o)
    );

    ex_alu u_alu (
        .inst_i       (inst_i),
        .reg_t_i      (reg_t_i),
        .reg_d_i      (reg_d_i),
        .rs_val_i     (rs_val_i),
        .rt_val_i     (rt_val_i),
        .mul_val_i    (mul_val),
        .bit_val_i    (bit_val),
        .imm_i        (imm_i),
        .hilo_i       (hilo),
        .val_o        (val_o),
        .wb_addr_o    (wb_addr_o),
        .overflow_o   (overflow_o),
        .move_hi_en_o (move_hi_en),
        .move_lo_en_o (move_lo_en),
        .move_val_o   (move_val)
    );

    ex_hilo u_hilo (
        .clk           (clk),
        .rst_n         (rst_n),
        .move_hi_en_i  (move_hi_en),
        .move_lo_en_i  (move_lo_en),
        .move_val_i    (move_val),
        .hilo_wr_en_i  (hilo_wr_en),
        .hilo_wr_val_i (hilo_wr_val),
        .hilo_o        (hilo)
    );

endmodule

`default_nettype wire

/* tb_clkgen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock source, 10 ns period
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk_o
);

    initial
    begin
        clk_o = 1'b0;
    end

    always #5 clk_o = ~clk_o;

endmodule

`default_nettype wire

/* tb_ex_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage testbench
// table of directed and random rows with expected
// writeback, destination, overflow and divider stall
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;

    localparam int MAX_ROWS = 96;
    localparam ex_pkg::reg_addr_t RD = 5'd3;
    localparam ex_pkg::reg_addr_t RT = 5'd9;

    logic clk;
    logic rst_n;
    logic flush_i;
    ex_pkg::inst_t inst_i;
    ex_pkg::reg_addr_t reg_s_i;
    ex_pkg::reg_addr_t reg_t_i;
    ex_pkg::reg_addr_t reg_d_i;
    ex_pkg::word_t rs_val_i;
    ex_pkg::word_t rt_val_i;
    ex_pkg::imm_t imm_i;
    ex_pkg::shamt_t shamt_i;
    ex_pkg::word_t val_o;
    ex_pkg::reg_addr_t wb_addr_o;
    logic overflow_o;
    logic stall_o;

    // stimulus and expected values
    ex_pkg::inst_t     t_inst [MAX_ROWS];
    ex_pkg::word_t     t_rs   [MAX_ROWS];
    ex_pkg::word_t     t_rt   [MAX_ROWS];
    ex_pkg::imm_t      t_imm  [MAX_ROWS];
    ex_pkg::shamt_t    t_sh   [MAX_ROWS];
    ex_pkg::word_t     t_val  [MAX_ROWS];
    ex_pkg::reg_addr_t t_addr [MAX_ROWS];
    logic              t_ovf  [MAX_ROWS];
    int                t_fl   [MAX_ROWS];
    int n_rows = 0;
    logic table_ready = 1'b0;
    integer seed = 32'ha9e9_3c59;

    tb_clkgen u_clkgen (.clk_o(clk));

    ex_stage ex_stage_inst (
        .clk(clk), .rst_n(rst_n), .flush_i(flush_i), .inst_i(inst_i),
        .reg_s_i(reg_s_i), .reg_t_i(reg_t_i), .reg_d_i(reg_d_i),
        .rs_val_i(rs_val_i), .rt_val_i(rt_val_i), .imm_i(imm_i), .shamt_i(shamt_i),
        .val_o(val_o), .wb_addr_o(wb_addr_o), .overflow_o(overflow_o), .stall_o(stall_o)
    );

    task automatic add_row(input ex_pkg::inst_t op, input ex_pkg::word_t rs,
                           input ex_pkg::word_t rt, input ex_pkg::imm_t imm,
                           input ex_pkg::shamt_t sh, input ex_pkg::word_t ev,
                           input ex_pkg::reg_addr_t ea, input logic eo, input int fl);
        t_inst[n_rows] = op;
        t_rs[n_rows]   = rs;
        t_rt[n_rows]   = rt;
        t_imm[n_rows]  = imm;
        t_sh[n_rows]   = sh;
        t_val[n_rows]  = ev;
        t_addr[n_rows] = ea;
        t_ovf[n_rows]  = eo;
        t_fl[n_rows]   = fl;
        n_rows++;
    endtask

    task automatic check_word(input ex_pkg::word_t got, input ex_pkg::word_t exp,
                              input string what);
        if (got !== exp)
        begin
            $display("Fail %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic check_addr(input ex_pkg::reg_addr_t got, input ex_pkg::reg_addr_t exp,
                              input string what);
        if (got !== exp)
        begin
            $display("Fail %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("Fail %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    // reference results for the randomized register ops
    function automatic ex_pkg::word_t model_val(input ex_pkg::inst_t op,
                                                input ex_pkg::word_t rs,
                                                input ex_pkg::word_t rt,
                                                input ex_pkg::shamt_t sh);
        ex_pkg::word_t r;
        int n;
        r = '0;
        case (op)
            ex_pkg::INST_ADDU: r = rs + rt;
            ex_pkg::INST_SUBU: r = rs - rt;
            ex_pkg::INST_SLT:  r = ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
            ex_pkg::INST_SLTU: r = (rs < rt) ? 32'd1 : 32'd0;
            ex_pkg::INST_XOR:  r = rs ^ rt;
            ex_pkg::INST_NOR:  r = ~(rs | rt);
            ex_pkg::INST_SLL:  r = rt << sh;
            ex_pkg::INST_SRAV: r = $signed(rt) >>> rs[4:0];
            ex_pkg::INST_MUL:  r = rs * rt;
            ex_pkg::INST_CLZ, ex_pkg::INST_CLO:
            begin
                n = 0;
                while (n < 32 && rs[31 - n] == (op == ex_pkg::INST_CLO))
                    n++;
                r = n;
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic build_table();
        ex_pkg::inst_t ops [10];
        ex_pkg::word_t a;
        ex_pkg::word_t b;
        ex_pkg::shamt_t s;
        ops = '{ex_pkg::INST_ADDU, ex_pkg::INST_SUBU, ex_pkg::INST_SLT, ex_pkg::INST_SLTU,
                ex_pkg::INST_XOR, ex_pkg::INST_NOR, ex_pkg::INST_SLL, ex_pkg::INST_SRAV,
                ex_pkg::INST_MUL, ex_pkg::INST_CLZ};
        add_row(ex_pkg::INST_ADD,   5, 7, 0, 0, 12, RD, 0, 0);
        add_row(ex_pkg::INST_ADD,   32'h7fffffff, 1, 0, 0, 32'h80000000, 0, 1, 0);
        add_row(ex_pkg::INST_ADDU,  32'h7fffffff, 1, 0, 0, 32'h80000000, RD, 0, 0);
        add_row(ex_pkg::INST_SUB,   32'h80000000, 1, 0, 0, 32'h7fffffff, 0, 1, 0);
        add_row(ex_pkg::INST_SUBU,  10, 3, 0, 0, 7, RD, 0, 0);
        add_row(ex_pkg::INST_ADDI,  32'h7fffffff, 0, 16'h0001, 0, 32'h80000000, 0, 1, 0);
        add_row(ex_pkg::INST_ADDIU, 5, 0, 16'hffff, 0, 4, RT, 0, 0);
        add_row(ex_pkg::INST_SLTI,  32'hfffffffe, 0, 16'hffff, 0, 1, RT, 0, 0);
        add_row(ex_pkg::INST_SLTIU, 5, 0, 16'hffff, 0, 1, RT, 0, 0);
        add_row(ex_pkg::INST_AND,   32'hff00ff00, 32'h0ff00ff0, 0, 0, 32'h0f000f00, RD, 0, 0);
        add_row(ex_pkg::INST_OR,    32'hff00ff00, 32'h0ff00ff0, 0, 0, 32'hfff0fff0, RD, 0, 0);
        add_row(ex_pkg::INST_ORI,   32'h12340000, 0, 16'h00ff, 0, 32'h123400ff, RT, 0, 0);
        add_row(ex_pkg::INST_ANDI,  32'hffffffff, 0, 16'h8001, 0, 32'h00008001, RT, 0, 0);
        add_row(ex_pkg::INST_XORI,  32'hf0f0f0f0, 0, 16'hffff, 0, 32'hf0f00f0f, RT, 0, 0);
        add_row(ex_pkg::INST_LUI,   0, 0, 16'habcd, 0, 32'habcd0000, RT, 0, 0);
        add_row(ex_pkg::INST_MOVZ,  32'h55, 0, 0, 0, 32'h55, RD, 0, 0);
        add_row(ex_pkg::INST_MOVZ,  32'h55, 1, 0, 0, 32'h55, 0, 0, 0);
        add_row(ex_pkg::INST_MOVN,  32'h55, 1, 0, 0, 32'h55, RD, 0, 0);
        add_row(ex_pkg::INST_MOVN,  32'h55, 0, 0, 0, 32'h55, 0, 0, 0);
        add_row(ex_pkg::INST_SLL,   0, 1, 0, 4, 32'h10, RD, 0, 0);
        add_row(ex_pkg::INST_SRL,   0, 32'h80000000, 0, 31, 1, RD, 0, 0);
        add_row(ex_pkg::INST_SRA,   0, 32'h80000000, 0, 4, 32'hf8000000, RD, 0, 0);
        add_row(ex_pkg::INST_SLLV,  33, 3, 0, 0, 6, RD, 0, 0);
        add_row(ex_pkg::INST_SRLV,  4, 32'hf0, 0, 0, 32'hf, RD, 0, 0);
        add_row(ex_pkg::INST_SRAV,  8, 32'hfffff000, 0, 0, 32'hfffffff0, RD, 0, 0);
        add_row(ex_pkg::INST_CLZ,   0, 0, 0, 0, 32, RD, 0, 0);
        add_row(ex_pkg::INST_CLO,   32'hffffffff, 0, 0, 0, 32, RD, 0, 0);
        add_row(ex_pkg::INST_CLZ,   1, 0, 0, 0, 31, RD, 0, 0);
        add_row(ex_pkg::INST_CLO,   0, 0, 0, 0, 0, RD, 0, 0);
        // HI/LO through multiply and moves
        add_row(ex_pkg::INST_MULT,  32'hfffffffd, 5, 0, 0, 0, 0, 0, 0);
        add_row(ex_pkg::INST_MFHI,  0, 0, 0, 0, 32'hffffffff, RD, 0, 0);
        add_row(ex_pkg::INST_MFLO,  0, 0, 0, 0, 32'hfffffff1, RD, 0, 0);
        add_row(ex_pkg::INST_MULTU, 32'hffffffff, 2, 0, 0, 0, 0, 0, 0);
        add_row(ex_pkg::INST_MFHI,  0, 0, 0, 0, 1, RD, 0, 0);
        add_row(ex_pkg::INST_MFLO,  0, 0, 0, 0, 32'hfffffffe, RD, 0, 0);
        add_row(ex_pkg::INST_MUL,   32'h10000, 32'h10001, 0, 0, 32'h10000, RD, 0, 0);
        add_row(ex_pkg::INST_MTHI,  32'haaaa, 0, 0, 0, 0, 0, 0, 0);
        add_row(ex_pkg::INST_MFHI,  0, 0, 0, 0, 32'haaaa, RD, 0, 0);
        add_row(ex_pkg::INST_MFLO,  0, 0, 0, 0, 32'hfffffffe, RD, 0, 0);
        add_row(ex_pkg::INST_MTLO,  32'h5555, 0, 0, 0, 0, 0, 0, 0);
        add_row(ex_pkg::INST_MFHI,  0, 0, 0, 0, 32'haaaa, RD, 0, 0);
        add_row(ex_pkg::INST_MFLO,  0, 0, 0, 0, 32'h5555, RD, 0, 0);
        // -7/2 gives -3 rem -1, then 100/7, by zero and a flushed divide
        add_row(ex_pkg::INST_DIV,   32'hfffffff9, 2, 0, 0, 0, 0, 0, 0);
        add_row(ex_pkg::INST_MFLO,  0, 0, 0, 0, 32'hfffffffd, RD, 0, 0);
        add_row(ex_pkg::INST_MFHI,  0, 0, 0, 0, 32'hffffffff, RD, 0, 0);
        add_row(ex_pkg::INST_DIVU,  100, 7, 0, 0, 0, 0, 0, 0);
        add_row(ex_pkg::INST_MFLO,  0, 0, 0, 0, 14, RD, 0, 0);
        add_row(ex_pkg::INST_DIV,   5, 0, 0, 0, 0, 0, 0, 0);
        add_row(ex_pkg::INST_MFLO,  0, 0, 0, 0, 14, RD, 0, 0);
        add_row(ex_pkg::INST_DIV,   32'h1000, 3, 0, 0, 0, 0, 0, 5);
        add_row(ex_pkg::INST_MFLO,  0, 0, 0, 0, 14, RD, 0, 0);
        add_row(ex_pkg::INST_MFHI,  0, 0, 0, 0, 2, RD, 0, 0);
        for (int i = 0; i < 30; i++)
        begin
            a = $random(seed);
            b = $random(seed);
            s = ex_pkg::shamt_t'($random(seed));
            add_row(ops[i % 10], a, b, 0, s, model_val(ops[i % 10], a, b, s), RD, 0, 0);
        end
        add_row(ex_pkg::INST_CLO, 32'hfff0_1234, 0, 0, 0,
                model_val(ex_pkg::INST_CLO, 32'hfff0_1234, 0, 0), RD, 0, 0);
    endtask

    task automatic run_row(input int i);
        int cycles;
        logic is_div;
        flush_i  = 1'b0;
        inst_i   = t_inst[i];
        rs_val_i = t_rs[i];
        rt_val_i = t_rt[i];
        imm_i    = t_imm[i];
        shamt_i  = t_sh[i];
        is_div   = (t_inst[i] == ex_pkg::INST_DIV) || (t_inst[i] == ex_pkg::INST_DIVU);
        #7;
        check_flag(stall_o, is_div, "stall_o at issue");
        cycles = 0;
        // inputs stay put while the divider runs
        while (stall_o)
        begin
            @(posedge clk);
            #1;
            cycles++;
            if (t_fl[i] != 0 && cycles == t_fl[i])
                flush_i = 1'b1;
            #7;
        end
        if (is_div)
        begin
            if (t_fl[i] != 0)
                check_word(ex_pkg::word_t'(cycles), t_fl[i], "flushed stall length");
            else if (t_rt[i] == 0)
                check_word(ex_pkg::word_t'(cycles), 1, "divide by zero stall length");
            else
                check_word(ex_pkg::word_t'(cycles), ex_pkg::DIV_STEPS + 1, "stall length");
        end
        check_word(val_o, t_val[i], "val_o");
        check_addr(wb_addr_o, t_addr[i], "wb_addr_o");
        check_flag(overflow_o, t_ovf[i], "overflow_o");
        @(posedge clk);
        #1;
    endtask

    initial
    begin
        wait (table_ready);
        #((n_rows * (ex_pkg::DIV_STEPS + 4) + 20) * 10);
        $display("timeout: the DUT did not get through the test table in time");
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        rst_n    = 1'b0;
        flush_i  = 1'b0;
        inst_i   = ex_pkg::INST_NOP;
        reg_s_i  = 5'd1;
        reg_t_i  = RT;
        reg_d_i  = RD;
        rs_val_i = '0;
        rt_val_i = '0;
        imm_i    = '0;
        shamt_i  = '0;
        build_table();
        table_ready = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_flag(stall_o, 1'b0, "stall_o after reset");
        for (int i = 0; i < n_rows; i++)
            run_row(i);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
ex_pkg.sv
ex_bitops.sv
ex_alu.sv
ex_muldiv.sv
ex_hilo.sv
ex_stage.sv
tb_clkgen.sv
tb_ex_stage.sv

/* run.sh */
#!/bin/sh
# build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_ex_stage -f tb.f -o sim_ex_stage

./obj_dir/sim_ex_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
grep -q "TEST OK" sim.log
